/* vlog.f */
fetch_pkg.sv
line_fetcher.sv
line_buffer.sv
byte_aligner.sv
fetch_top.sv
fetch_properties.sv
tb_clock_gen.sv
tb_imem.sv
tb_fetch_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top -f vlog.f

out=$(./obj_dir/Vtb_fetch_top) || true
echo "$out"
echo "$out" | grep -qx "test passed"

/* tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top;

    logic                     clk;
    logic                     por_reset;
    logic                     run_reset;
    logic                     reset_i;
    logic                     redirect_valid_i;
    fetch_pkg::redirect_t     redirect_i;
    logic                     mem_req_valid_o;
    logic                     mem_req_ready_i;
    fetch_pkg::mem_req_t      mem_req_o;
    logic                     mem_rsp_valid_i;
    fetch_pkg::mem_rsp_t      mem_rsp_i;
    logic                     pkt_valid_o;
    logic                     pkt_ready_i;
    fetch_pkg::fetch_packet_t pkt_o;
    fetch_pkg::insn_len_t     insn_len_i;
    logic                     mem_slow;
    logic                     stall_mode;
    integer                   seed;

    assign reset_i = por_reset | run_reset;

    tb_clock_gen u_clock (
        .clk_o   (clk),
        .reset_o (por_reset)
    );

    tb_imem u_imem (
        .clk         (clk),
        .reset_i     (reset_i),
        .slow_i      (mem_slow),
        .req_valid_i (mem_req_valid_o),
        .req_ready_o (mem_req_ready_i),
        .req_i       (mem_req_o),
        .rsp_valid_o (mem_rsp_valid_i),
        .rsp_o       (mem_rsp_i)
    );

    fetch_top dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_i       (redirect_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i),
        .pkt_valid_o      (pkt_valid_o),
        .pkt_ready_i      (pkt_ready_i),
        .pkt_o            (pkt_o),
        .insn_len_i       (insn_len_i)
    );

    ////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////

    // byte k of the packet is memory byte pc + k
    function automatic fetch_pkg::line_data_t packet_bytes(input fetch_pkg::fetch_addr_t pc);
        fetch_pkg::line_data_t  d;
        fetch_pkg::fetch_addr_t a;
        for (int k = 0; k < 16; k++) begin
            a = pc + 32'(k);
            d[k*8 +: 8] = a[7:0] ^ a[15:8];
        end
        return d;
    endfunction

    // a split packet also sees the following line
    function automatic logic packet_fault(input fetch_pkg::fetch_addr_t pc);
        fetch_pkg::fetch_addr_t next_line;
        next_line = {pc[31:4] + 28'd1, 4'h0};
        return (pc >= 32'h0000_f000) || ((pc[3:0] != 4'h0) && (next_line >= 32'h0000_f000));
    endfunction

    function automatic fetch_pkg::insn_len_t random_len();
        return fetch_pkg::insn_len_t'({$random(seed)} % 15 + 1);
    endfunction

    ////////////////////////////////////////////////////////////
    // drive and check helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [127:0] exp, input logic [127:0] act);
        $display("FAIL %s %s expected %0h actual %0h", test, field, exp, act);
        stop_run();
    endtask

    task automatic check_packet(input string test, input fetch_pkg::fetch_addr_t pc);
        fetch_pkg::line_data_t exp_data;
        logic                  exp_fault;
        exp_data = packet_bytes(pc);
        exp_fault = packet_fault(pc);
        assert (pkt_o.pc == pc)
            else report_mismatch(test, "pc", 128'(pc), 128'(pkt_o.pc));
        assert (pkt_o.data == exp_data)
            else report_mismatch(test, "bytes", exp_data, pkt_o.data);
        assert (pkt_o.fault == exp_fault)
            else report_mismatch(test, "fault", 128'(exp_fault), 128'(pkt_o.fault));
    endtask

    task automatic take_packet(input string test, inout fetch_pkg::fetch_addr_t pc);
        fetch_pkg::insn_len_t len;
        int                   stall;
        int                   waited;
        len = random_len();
        stall = 0;
        waited = 0;
        if (stall_mode && ({$random(seed)} % 2 == 0)) begin
            stall = int'({$random(seed)} % 21);
        end
        while (!pkt_valid_o) begin
            @(negedge clk);
            waited++;
            if (waited >= 200) begin
                $display("no packet within 200 cycles in %s at pc %0h", test, pc);
                stop_run();
            end
        end
        // decoder not ready yet
        repeat (stall) @(negedge clk);
        check_packet(test, pc);
        pkt_ready_i = 1'b1;
        insn_len_i = len;
        @(negedge clk);
        pkt_ready_i = 1'b0;
        pc = pc + 32'(len);
    endtask

    task automatic send_redirect(input fetch_pkg::fetch_addr_t addr);
        redirect_valid_i = 1'b1;
        redirect_i.addr = addr;
        @(negedge clk);
        redirect_valid_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic stream_after_reset();
        fetch_pkg::fetch_addr_t pc;
        pc = fetch_pkg::RESET_PC;
        repeat (60) take_packet("stream_after_reset", pc);
    endtask

    task automatic back_pressure();
        fetch_pkg::fetch_addr_t pc;
        pc = 32'h0000_0400;
        send_redirect(pc);
        mem_slow = 1'b1;
        stall_mode = 1'b1;
        repeat (40) take_packet("back_pressure", pc);
        mem_slow = 1'b0;
        stall_mode = 1'b0;
    endtask

    task automatic redirect_mid_stream();
        fetch_pkg::fetch_addr_t pc;
        int                     tries;
        pc = 32'h0000_0200;
        tries = 0;
        send_redirect(pc);
        // keep consuming until lines are in flight
        while (dut.u_fetcher.outstanding_q == '0) begin
            take_packet("redirect_mid_stream", pc);
            tries++;
            if (tries >= 200) begin
                $display("no outstanding memory request seen in redirect_mid_stream");
                stop_run();
            end
        end
        pc = 32'h0000_1237;
        send_redirect(pc);
        repeat (5) take_packet("redirect_mid_stream", pc);
        send_redirect(32'h0000_2345);
        @(negedge clk);
        pc = 32'h0000_40b9;
        send_redirect(pc);
        repeat (20) take_packet("redirect_mid_stream", pc);
    endtask

    task automatic fault_region();
        fetch_pkg::fetch_addr_t pc;
        // aligned at 0xeff0 so only the clean line is read
        pc = 32'h0000_eff0;
        send_redirect(pc);
        take_packet("fault_region", pc);
        pc = 32'h0000_effa;
        send_redirect(pc);
        while (pc < 32'h0000_f030) begin
            take_packet("fault_region", pc);
        end
    endtask

    task automatic reset_mid_run();
        fetch_pkg::fetch_addr_t pc;
        fetch_pkg::line_addr_t  first_line;
        pc = 32'h0000_0800;
        first_line = fetch_pkg::line_addr_t'(fetch_pkg::RESET_PC / fetch_pkg::LINE_BYTES);
        send_redirect(pc);
        repeat (10) take_packet("reset_mid_run", pc);
        run_reset = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!pkt_valid_o)
                else report_mismatch("reset_mid_run", "pkt_valid", 128'(0), 128'(pkt_valid_o));
            assert (!mem_req_valid_o)
                else report_mismatch("reset_mid_run", "mem_req_valid",
                                     128'(0), 128'(mem_req_valid_o));
        end
        run_reset = 1'b0;
        @(negedge clk);
        assert (!pkt_valid_o)
            else report_mismatch("reset_mid_run", "pkt_valid", 128'(0), 128'(pkt_valid_o));
        // first request goes out one cycle after release
        assert (mem_req_valid_o)
            else report_mismatch("reset_mid_run", "mem_req_valid",
                                 128'(1), 128'(mem_req_valid_o));
        assert (mem_req_o.line == first_line)
            else report_mismatch("reset_mid_run", "mem_req_line",
                                 128'(first_line), 128'(mem_req_o.line));
        pc = fetch_pkg::RESET_PC;
        repeat (20) take_packet("reset_mid_run", pc);
    endtask

    initial begin
        int waited;
        seed = 32'h82d0;
        run_reset = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_i = '0;
        pkt_ready_i = 1'b0;
        insn_len_i = 4'd1;
        mem_slow = 1'b0;
        stall_mode = 1'b0;
        waited = 0;
        @(negedge clk);
        while (reset_i) begin
            @(negedge clk);
            waited++;
            if (waited >= 10) begin
                $display("reset was never released");
                stop_run();
            end
        end
        stream_after_reset();
        back_pressure();
        redirect_mid_stream();
        fault_region();
        reset_mid_run();
        $display("test passed");
        $finish;
    end

endmodule

/* tb_imem.sv */
`timescale 1ns/100ps

module tb_imem (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 slow_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  fetch_pkg::mem_req_t  req_i,
    output logic                 rsp_valid_o,
    output fetch_pkg::mem_rsp_t  rsp_o
);

    fetch_pkg::line_addr_t pend_line [$];
    int                    pend_due [$];
    int                    cycle;
    integer                seed;
    logic                  slow_q;

    // byte at a is a[7:0] ^ a[15:8]
    function automatic fetch_pkg::line_data_t line_bytes(input fetch_pkg::line_addr_t line);
        fetch_pkg::line_data_t  d;
        fetch_pkg::fetch_addr_t a;
        for (int k = 0; k < 16; k++) begin
            a = {line, 4'(k)};
            d[k*8 +: 8] = a[7:0] ^ a[15:8];
        end
        return d;
    endfunction

    initial begin
        seed = 32'h82d0;
        cycle = 0;
        slow_q = 1'b0;
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_o = '0;
    end

    // bookkeeping on the rising edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        slow_q = slow_i;
        if (reset_i) begin
            pend_line.delete();
            pend_due.delete();
        end else begin
            if (rsp_valid_o) begin
                void'(pend_line.pop_front());
                void'(pend_due.pop_front());
            end
            if (req_valid_i && req_ready_o) begin
                pend_line.push_back(req_i.line);
                // 1 to 4 cycles, served strictly in order
                pend_due.push_back(cycle + int'({$random(seed)} % 4));
            end
        end
    end

    always @(negedge clk) begin
        if (slow_q) begin
            req_ready_o <= ({$random(seed)} % 4) == 0;
        end else begin
            req_ready_o <= ({$random(seed)} % 4) != 0;
        end
        if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
            rsp_valid_o <= 1'b1;
            rsp_o.data <= line_bytes(pend_line[0]);
            // fault region from byte 0xf000 up
            rsp_o.fault <= (pend_line[0] >= 28'h000_0f00);
        end else begin
            rsp_valid_o <= 1'b0;
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // three rising edges in reset, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* fetch_properties.sv */
`timescale 1ns/100ps

module fetch_properties (
    input logic                      clk,
    input logic                      reset_i,
    input logic                      redirect_valid_i,
    input logic                      req_valid_i,
    input logic                      req_ready_i,
    input fetch_pkg::mem_req_t       req_i,
    input logic                      pkt_valid_i,
    input logic                      pkt_ready_i,
    input fetch_pkg::fetch_packet_t  pkt_i,
    input fetch_pkg::fetcher_state_t state_i
);

    // a waiting request keeps its line
    assert property (@(posedge clk) disable iff (reset_i)
        req_valid_i && !req_ready_i && !redirect_valid_i |=> req_valid_i && $stable(req_i))
        else $error("memory request changed before it was accepted");

    // decoder stall holds the packet
    assert property (@(posedge clk) disable iff (reset_i)
        pkt_valid_i && !pkt_ready_i && !redirect_valid_i |=> pkt_valid_i && $stable(pkt_i))
        else $error("packet changed before it was consumed");

    // buffer is empty right after a flush
    assert property (@(posedge clk)
        reset_i || redirect_valid_i |=> !pkt_valid_i)
        else $error("packet valid in the cycle after a reset or redirect");

    // stale lines never reach the aligner
    assert property (@(posedge clk) disable iff (reset_i)
        state_i == fetch_pkg::DRAIN |-> !pkt_valid_i)
        else $error("packet valid while stale responses were being drained");

endmodule

bind fetch_top fetch_properties u_props (
    .clk              (clk),
    .reset_i          (reset_i),
    .redirect_valid_i (redirect_valid_i),
    .req_valid_i      (mem_req_valid_o),
    .req_ready_i      (mem_req_ready_i),
    .req_i            (mem_req_o),
    .pkt_valid_i      (pkt_valid_o),
    .pkt_ready_i      (pkt_ready_i),
    .pkt_i            (pkt_o),
    .state_i          (u_fetcher.state_q)
);

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
    input  logic                      clk,
    input  logic                      reset_i,

    // resteer from writeback or branch predictor
    input  logic                      redirect_valid_i,
    input  fetch_pkg::redirect_t      redirect_i,

    // instruction memory
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output fetch_pkg::mem_req_t       mem_req_o,
    input  logic                      mem_rsp_valid_i,
    input  fetch_pkg::mem_rsp_t       mem_rsp_i,

    // decoder
    output logic                      pkt_valid_o,
    input  logic                      pkt_ready_i,
    output fetch_pkg::fetch_packet_t  pkt_o,
    input  fetch_pkg::insn_len_t      insn_len_i
);

    logic                 fill_valid;
    fetch_pkg::mem_rsp_t  fill;
    logic                 pop_done;
    logic                 pop_req;
    fetch_pkg::buf_view_t buf_view;

    ////////////////////////////////////////////////////////////
    // line fetch
    ////////////////////////////////////////////////////////////

    line_fetcher u_fetcher (
        .clk              (clk),
        .reset_i          (reset_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_i       (redirect_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i),
        .pop_done_i       (pop_done),
        .fill_valid_o     (fill_valid),
        .fill_o           (fill)
    );

    // four lines between fetch and alignment
    line_buffer u_buffer (
        .clk              (clk),
        .reset_i          (reset_i),
        .redirect_valid_i (redirect_valid_i),
        .fill_valid_i     (fill_valid),
        .fill_i           (fill),
        .pop_i            (pop_req),
        .pop_done_o       (pop_done),
        .view_o           (buf_view)
    );

    ////////////////////////////////////////////////////////////
    // byte alignment
    ////////////////////////////////////////////////////////////

    byte_aligner u_aligner (
        .clk              (clk),
        .reset_i          (reset_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_i       (redirect_i),
        .view_i           (buf_view),
        .pkt_valid_o      (pkt_valid_o),
        .pkt_ready_i      (pkt_ready_i),
        .insn_len_i       (insn_len_i),
        .pkt_o            (pkt_o),
        .pop_o            (pop_req)
    );

endmodule

/* byte_aligner.sv */
`timescale 1ns/100ps

module byte_aligner (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      redirect_valid_i,
    input  fetch_pkg::redirect_t      redirect_i,
    input  fetch_pkg::buf_view_t      view_i,
    output logic                      pkt_valid_o,
    input  logic                      pkt_ready_i,
    input  fetch_pkg::insn_len_t      insn_len_i,
    output fetch_pkg::fetch_packet_t  pkt_o,
    output logic                      pop_o
);

    fetch_pkg::fetch_addr_t                   ptr_q;
    fetch_pkg::fetch_addr_t                   ptr_next;
    logic [fetch_pkg::LINE_OFFSET_BITS-1:0]   offset;
    logic                                     aligned;
    logic [2*fetch_pkg::LINE_BYTES*8-1:0]     window;
    logic [2*fetch_pkg::LINE_BYTES*8-1:0]     rotated;
    logic                                     consume;

    assign offset = ptr_q[fetch_pkg::LINE_OFFSET_BITS-1:0];
    assign aligned = (offset == '0);

    ////////////////////////////////////////////////////////////
    // packet assembly
    ////////////////////////////////////////////////////////////

    // an unaligned packet spills into the next line
    assign pkt_valid_o = view_i.head_valid & (aligned | view_i.next_valid);

    // head in the low half so byte k sits at ptr + k
    assign window = {view_i.next_data, view_i.head_data};
    assign rotated = window >> {offset, 3'b000};

    always_comb begin
        pkt_o.data = rotated[fetch_pkg::LINE_BYTES*8-1:0];
        pkt_o.pc = ptr_q;
        // second line only matters when some bytes come from it
        pkt_o.fault = view_i.head_fault | (~aligned & view_i.next_fault);
    end

    ////////////////////////////////////////////////////////////
    // pointer advance
    ////////////////////////////////////////////////////////////

    assign consume = pkt_valid_o & pkt_ready_i;
    assign ptr_next = ptr_q + fetch_pkg::fetch_addr_t'(insn_len_i);

    // at most 15 bytes, so at most one line crossed
    assign pop_o = consume & ~redirect_valid_i
                   & (ptr_next[31:fetch_pkg::LINE_OFFSET_BITS]
                      != ptr_q[31:fetch_pkg::LINE_OFFSET_BITS]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ptr_q <= fetch_pkg::RESET_PC;
        end else if (redirect_valid_i) begin
            ptr_q <= redirect_i.addr;
        end else if (consume) begin
            ptr_q <= ptr_next;
        end
    end

endmodule

/* line_buffer.sv */
`timescale 1ns/100ps

module line_buffer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  redirect_valid_i,
    input  logic                  fill_valid_i,
    input  fetch_pkg::mem_rsp_t   fill_i,
    input  logic                  pop_i,
    output logic                  pop_done_o,
    output fetch_pkg::buf_view_t  view_o
);

    fetch_pkg::line_data_t                data_q [fetch_pkg::BUF_LINES];
    logic [fetch_pkg::BUF_LINES-1:0]      fault_q;
    logic [fetch_pkg::BUF_LINES-1:0]      valid_q;
    logic [fetch_pkg::BUF_IDX_BITS-1:0]   head_q;
    logic [fetch_pkg::BUF_IDX_BITS-1:0]   tail_q;
    logic [fetch_pkg::BUF_IDX_BITS-1:0]   next_idx;
    logic                                 fill_fire;
    logic                                 pop_fire;

    // redirect wins over both fill and pop
    assign fill_fire = fill_valid_i & ~redirect_valid_i;
    assign pop_fire = pop_i & valid_q[head_q] & ~redirect_valid_i;

    // one pulse per freed slot, fetcher takes it back as a credit
    assign pop_done_o = pop_fire;

    assign next_idx = head_q + 1'b1;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // credits keep the fill off a live entry
    always_ff @(posedge clk) begin
        if (fill_fire) begin
            data_q[tail_q] <= fill_i.data;
            fault_q[tail_q] <= fill_i.fault;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and valid bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else if (redirect_valid_i) begin
            // flush, no pop_done since the fetcher rebuilds its credits
            valid_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (fill_fire) begin
                valid_q[tail_q] <= 1'b1;
                tail_q <= tail_q + 1'b1;
            end
            if (pop_fire) begin
                valid_q[head_q] <= 1'b0;
                head_q <= next_idx;
            end
        end
    end

    // head line and its successor for the aligner
    always_comb begin
        view_o.head_data = data_q[head_q];
        view_o.head_valid = valid_q[head_q];
        view_o.head_fault = fault_q[head_q];
        view_o.next_data = data_q[next_idx];
        view_o.next_valid = valid_q[next_idx];
        view_o.next_fault = fault_q[next_idx];
    end

endmodule

/* line_fetcher.sv */
`timescale 1ns/100ps

module line_fetcher (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  redirect_valid_i,
    input  fetch_pkg::redirect_t  redirect_i,
    output logic                  mem_req_valid_o,
    input  logic                  mem_req_ready_i,
    output fetch_pkg::mem_req_t   mem_req_o,
    input  logic                  mem_rsp_valid_i,
    input  fetch_pkg::mem_rsp_t   mem_rsp_i,
    input  logic                  pop_done_i,
    output logic                  fill_valid_o,
    output fetch_pkg::mem_rsp_t   fill_o
);

    fetch_pkg::line_addr_t     line_addr_q;
    fetch_pkg::line_addr_t     line_addr_d;
    fetch_pkg::credit_t        credits_q;
    fetch_pkg::credit_t        credits_d;
    fetch_pkg::credit_t        outstanding_q;
    fetch_pkg::credit_t        outstanding_d;
    fetch_pkg::credit_t        drain_q;
    fetch_pkg::credit_t        drain_d;
    fetch_pkg::fetcher_state_t state_q;
    fetch_pkg::fetcher_state_t state_d;
    logic                      req_valid_q;
    logic                      req_valid_d;
    logic                      req_accept;
    logic                      rsp_discard;

    assign req_accept = req_valid_q & mem_req_ready_i;

    // responses still owed to the old stream are thrown away
    assign rsp_discard = mem_rsp_valid_i & (state_q == fetch_pkg::DRAIN);

    assign mem_req_valid_o = req_valid_q;
    assign mem_req_o.line = line_addr_q;

    // straight into the buffer, same cycle
    assign fill_valid_o = mem_rsp_valid_i & (state_q == fetch_pkg::RUN) & ~redirect_valid_i;
    assign fill_o = mem_rsp_i;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        outstanding_d = outstanding_q + fetch_pkg::credit_t'(req_accept)
                        - fetch_pkg::credit_t'(mem_rsp_valid_i);
        line_addr_d = line_addr_q;
        credits_d = credits_q;
        drain_d = drain_q;

        if (redirect_valid_i) begin
            line_addr_d = redirect_i.addr[31:fetch_pkg::LINE_OFFSET_BITS];
            // buffer is flushed, only in-flight lines still hold slots
            credits_d = fetch_pkg::credit_t'(fetch_pkg::BUF_LINES) - outstanding_d;
            drain_d = outstanding_d;
        end else begin
            if (req_accept) begin
                line_addr_d = line_addr_q + 1'b1;
            end
            credits_d = credits_q - fetch_pkg::credit_t'(req_accept)
                        + fetch_pkg::credit_t'(pop_done_i)
                        + fetch_pkg::credit_t'(rsp_discard);
            if (rsp_discard) begin
                drain_d = drain_q - 1'b1;
            end
        end

        state_d = (drain_d != '0) ? fetch_pkg::DRAIN : fetch_pkg::RUN;

        // credits only drop on acceptance, so a raised request stays up
        req_valid_d = ~redirect_valid_i & (credits_d != '0);
    end

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr_q <= fetch_pkg::line_addr_t'(
                               fetch_pkg::RESET_PC >> fetch_pkg::LINE_OFFSET_BITS);
            credits_q <= fetch_pkg::credit_t'(fetch_pkg::BUF_LINES);
            outstanding_q <= '0;
            drain_q <= '0;
            state_q <= fetch_pkg::RUN;
            req_valid_q <= 1'b0;
        end else begin
            line_addr_q <= line_addr_d;
            credits_q <= credits_d;
            outstanding_q <= outstanding_d;
            drain_q <= drain_d;
            state_q <= state_d;
            req_valid_q <= req_valid_d;
        end
    end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int unsigned LINE_BYTES = 16;
    localparam int unsigned LINE_OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int unsigned BUF_LINES = 4;
    localparam int unsigned BUF_IDX_BITS = $clog2(BUF_LINES);
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    // byte address
    typedef logic [31:0] fetch_addr_t;
    // byte address without the in-line offset
    typedef logic [27:0] line_addr_t;
    // byte 0 in bits 7:0
    typedef logic [127:0] line_data_t;
    // decoder length, 1 to 15
    typedef logic [3:0] insn_len_t;
    // free buffer slots, 0 to 4
    typedef logic [2:0] credit_t;

    ////////////////////////////////////////////////////////////
    // structs crossing module boundaries
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        line_addr_t line;
    } mem_req_t;

    typedef struct packed {
        line_data_t data;
        logic       fault;
    } mem_rsp_t;

    // head entry and the one behind it
    typedef struct packed {
        line_data_t head_data;
        logic       head_valid;
        logic       head_fault;
        line_data_t next_data;
        logic       next_valid;
        logic       next_fault;
    } buf_view_t;

    typedef struct packed {
        line_data_t  data;
        fetch_addr_t pc;
        logic        fault;
    } fetch_packet_t;

    typedef struct packed {
        fetch_addr_t addr;
    } redirect_t;

    // drain while responses to old lines are still in flight
    typedef enum logic {
        RUN,
        DRAIN
    } fetcher_state_t;

endpackage
